// File: verilog/fetchPkg.sv
package fetchPkg;

    localparam int SLOTS = 4; // instructions per fetch block and per cache line

    typedef logic [3:0] FetchId_t;

    // prediction for the block currently being looked up
    typedef enum logic [1:0] {
        PRED_NONE,
        PRED_NOT_TAKEN,
        PRED_TAKEN,
        PRED_JUMP
    } predKind_t;

    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_SETUP,
        FILL_ACCESS,
        FILL_WRITE,
        FILL_DONE
    } fillState_t;

    typedef struct packed {
        predKind_t kind;
        logic [1:0] srcSlot;
        logic [31:0] target;
    } BranchPred_t;

    // restart fetch after the given fetch id
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        FetchId_t fetchId;
    } Redirect_t;

    typedef struct packed {
        logic [29:0] pc; // word address of the block
        logic predTaken;
        logic [1:0] branchSlot;
    } PcFileEntry_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] instr;
        FetchId_t fetchId;
        logic predTaken;
    } FetchSlot_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic [31:0] paddr;
        logic pwrite;
    } ApbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic pready;
    } ApbRsp_t;

endpackage

// File: verilog/fetchPc.sv
`timescale 1ns/10ps

module fetchPc import fetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  BranchPred_t pred,
    input  Redirect_t redirect,
    input  logic ready,
    input  FetchId_t robFetchId,
    input  logic hit,
    input  logic [SLOTS-1:0][31:0] lineData,
    output logic [29:0] lookupAddr,
    output logic pcWrite,
    output FetchId_t pcWriteAddr,
    output PcFileEntry_t pcWriteData,
    output FetchSlot_t slots [SLOTS],
    output logic blockValid,
    output logic stall
);

    logic [31:0] pc;
    FetchId_t fetchId;
    logic taken;
    logic accept;
    logic [31:0] nextPc;
    FetchSlot_t nextSlots [SLOTS];

    assign lookupAddr = pc[31:2];
    assign taken = (pred.kind == PRED_TAKEN) || (pred.kind == PRED_JUMP);

    // the rob still holds this fetch id, so fetching on would overwrite its pc file entry
    assign stall = !hit || (robFetchId == fetchId);
    assign accept = !rst && !redirect.valid && hit && ready && (robFetchId != fetchId);

    assign nextPc = taken ? {pred.target[31:2], 2'b00} : {pc[31:4] + 28'd1, 4'b0000};

    assign pcWrite = accept;
    assign pcWriteAddr = fetchId;
    assign pcWriteData = '{pc: pc[31:2], predTaken: taken, branchSlot: pred.srcSlot};

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            nextSlots[i].pc = {pc[31:4], 2'(i), 2'b00};
            nextSlots[i].instr = lineData[i];
            nextSlots[i].fetchId = fetchId;
            // words before the entry point and after a taken branch are dropped
            nextSlots[i].valid = (2'(i) >= pc[3:2]) && (!taken || 2'(i) <= pred.srcSlot);
            nextSlots[i].predTaken = taken && (2'(i) == pred.srcSlot);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchId <= '0;
            blockValid <= 1'b0;
        end else if (redirect.valid) begin
            pc <= {redirect.pc[31:2], 2'b00};
            fetchId <= redirect.fetchId + 4'd1;
            blockValid <= 1'b0;
        end else if (accept) begin
            pc <= nextPc;
            fetchId <= fetchId + 4'd1;
            blockValid <= 1'b1;
        end else begin
            blockValid <= 1'b0; // slots keep their last contents
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slots <= nextSlots;
        end
    end

endmodule

// File: verilog/pcFile.sv
`timescale 1ns/10ps

module pcFile import fetchPkg::*; (
    input  logic clk,
    input  logic wen,
    input  FetchId_t waddr,
    input  PcFileEntry_t wdata,
    input  FetchId_t raddr0,
    input  FetchId_t raddr1,
    output PcFileEntry_t rdata0,
    output PcFileEntry_t rdata1
);

    // one entry per fetch id in flight
    PcFileEntry_t entries [16];

    always_ff @(posedge clk) begin
        if (wen) begin
            entries[waddr] <= wdata;
        end
    end

    assign rdata0 = entries[raddr0];
    assign rdata1 = entries[raddr1];

endmodule

// File: verilog/icacheArray.sv
`timescale 1ns/10ps

module icacheArray import fetchPkg::*; #(
    parameter int NUM_LINES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic [29:0] lookupAddr,
    input  logic fillWen,
    input  logic [27:0] fillLine,
    input  logic [1:0] fillWord,
    input  logic [31:0] fillData,
    input  logic tagWen,
    output logic hit,
    output logic [SLOTS-1:0][31:0] lineData
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = 28 - IDX_W;

    logic [NUM_LINES-1:0] valid;
    logic [TAG_W-1:0] tags [NUM_LINES];
    logic [SLOTS-1:0][31:0] lines [NUM_LINES];

    logic [IDX_W-1:0] lookupIdx;
    logic [TAG_W-1:0] lookupTag;
    logic [IDX_W-1:0] fillIdx;

    // word address splits into tag, index and a 2-bit word offset
    assign lookupIdx = lookupAddr[IDX_W+1:2];
    assign lookupTag = lookupAddr[29:IDX_W+2];
    assign fillIdx = fillLine[IDX_W-1:0];

    assign hit = valid[lookupIdx] && (tags[lookupIdx] == lookupTag);
    assign lineData = lines[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (tagWen) begin
            valid[fillIdx] <= 1'b1;
        end else if (fillWen) begin
            valid[fillIdx] <= 1'b0; // line holds mixed data until the fill completes
        end
    end

    always_ff @(posedge clk) begin
        if (fillWen) begin
            lines[fillIdx][fillWord] <= fillData;
        end
        if (tagWen) begin
            tags[fillIdx] <= fillLine[27:IDX_W];
        end
    end

endmodule

// File: verilog/fillControl.sv
`timescale 1ns/10ps

module fillControl import fetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic hit,
    input  logic [29:0] lookupAddr,
    input  logic [1:0] beat,
    input  logic [31:0] beatAddr,
    input  logic lastBeat,
    input  ApbRsp_t apbRsp,
    output ApbReq_t apbReq,
    output logic beatAdvance,
    output logic counterClear,
    output logic fillWen,
    output logic [27:0] fillLine,
    output logic [1:0] fillWord,
    output logic [31:0] fillData,
    output logic tagWen
);

    fillState_t state;
    logic [27:0] missLine;
    logic beatDone;

    assign beatDone = (state == FILL_ACCESS) && apbRsp.pready;

    // read-only master, one transfer per beat
    assign apbReq.psel = (state == FILL_SETUP) || (state == FILL_ACCESS);
    assign apbReq.penable = (state == FILL_ACCESS);
    assign apbReq.paddr = beatAddr;
    assign apbReq.pwrite = 1'b0;

    assign counterClear = (state == FILL_IDLE);
    assign beatAdvance = beatDone;
    assign fillWen = beatDone;
    assign fillWord = beat;
    assign fillData = apbRsp.prdata;
    assign fillLine = missLine;
    assign tagWen = (state == FILL_WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_IDLE;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (!hit) begin
                        state <= FILL_SETUP;
                    end
                end
                FILL_SETUP: state <= FILL_ACCESS;
                FILL_ACCESS: begin
                    if (apbRsp.pready) begin
                        state <= lastBeat ? FILL_WRITE : FILL_SETUP;
                    end
                end
                FILL_WRITE: state <= FILL_DONE;
                FILL_DONE: state <= FILL_IDLE;
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // the missing line is latched so a redirect mid-fill cannot change the target
    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && !hit) begin
            missLine <= lookupAddr[29:2];
        end
    end

endmodule

// File: verilog/fillCounter.sv
`timescale 1ns/10ps

module fillCounter (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic advance,
    input  logic [27:0] lineBase,
    output logic [1:0] beat,
    output logic [31:0] beatAddr,
    output logic lastBeat
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat <= 2'd0;
        end else if (advance) begin
            beat <= beat + 2'd1;
        end
    end

    assign beatAddr = {lineBase, beat, 2'b00}; // byte address of the current word
    assign lastBeat = (beat == 2'd3);

endmodule

// File: verilog/fetchTop.sv
`timescale 1ns/10ps

module fetchTop import fetchPkg::*; #(
    parameter int NUM_LINES = 8
) (
    input  logic clk,
    input  logic rst,
    input  BranchPred_t pred,
    input  Redirect_t redirect,
    input  logic ready,
    input  FetchId_t robFetchId,
    input  FetchId_t pcReadAddr0,
    input  FetchId_t pcReadAddr1,
    output PcFileEntry_t pcReadData0,
    output PcFileEntry_t pcReadData1,
    output FetchSlot_t slots [SLOTS],
    output logic blockValid,
    output logic stall,
    output ApbReq_t apbReq,
    input  ApbRsp_t apbRsp
);

    logic [29:0] lookupAddr;
    logic hit;
    logic [SLOTS-1:0][31:0] lineData;
    logic pcWrite;
    FetchId_t pcWriteAddr;
    PcFileEntry_t pcWriteData;
    logic [1:0] beat;
    logic [31:0] beatAddr;
    logic lastBeat;
    logic beatAdvance;
    logic counterClear;
    logic fillWen;
    logic [27:0] fillLine;
    logic [1:0] fillWord;
    logic [31:0] fillData;
    logic tagWen;

    fetchPc fetchPc_inst (
        .clk(clk),
        .rst(rst),
        .pred(pred),
        .redirect(redirect),
        .ready(ready),
        .robFetchId(robFetchId),
        .hit(hit),
        .lineData(lineData),
        .lookupAddr(lookupAddr),
        .pcWrite(pcWrite),
        .pcWriteAddr(pcWriteAddr),
        .pcWriteData(pcWriteData),
        .slots(slots),
        .blockValid(blockValid),
        .stall(stall)
    );

    pcFile pcFile_inst (
        .clk(clk),
        .wen(pcWrite),
        .waddr(pcWriteAddr),
        .wdata(pcWriteData),
        .raddr0(pcReadAddr0),
        .raddr1(pcReadAddr1),
        .rdata0(pcReadData0),
        .rdata1(pcReadData1)
    );

    icacheArray #(
        .NUM_LINES(NUM_LINES)
    ) icacheArray_inst (
        .clk(clk),
        .rst(rst),
        .lookupAddr(lookupAddr),
        .fillWen(fillWen),
        .fillLine(fillLine),
        .fillWord(fillWord),
        .fillData(fillData),
        .tagWen(tagWen),
        .hit(hit),
        .lineData(lineData)
    );

    fillControl fillControl_inst (
        .clk(clk),
        .rst(rst),
        .hit(hit),
        .lookupAddr(lookupAddr),
        .beat(beat),
        .beatAddr(beatAddr),
        .lastBeat(lastBeat),
        .apbRsp(apbRsp),
        .apbReq(apbReq),
        .beatAdvance(beatAdvance),
        .counterClear(counterClear),
        .fillWen(fillWen),
        .fillLine(fillLine),
        .fillWord(fillWord),
        .fillData(fillData),
        .tagWen(tagWen)
    );

    fillCounter fillCounter_inst (
        .clk(clk),
        .rst(rst),
        .clear(counterClear),
        .advance(beatAdvance),
        .lineBase(fillLine),
        .beat(beat),
        .beatAddr(beatAddr),
        .lastBeat(lastBeat)
    );

endmodule

// File: test/fetchChecker.sv
`timescale 1ns/10ps

module fetchChecker import fetchPkg::*; (
    input  logic clk,
    input  logic rst,
    input  BranchPred_t pred,
    input  Redirect_t redirect,
    input  logic ready,
    input  FetchId_t robFetchId,
    input  FetchId_t pcReadAddr0,
    input  FetchId_t pcReadAddr1,
    input  PcFileEntry_t pcReadData0,
    input  PcFileEntry_t pcReadData1,
    input  FetchSlot_t slots [SLOTS],
    input  logic blockValid,
    input  logic stall,
    input  ApbReq_t apbReq,
    input  ApbRsp_t apbRsp,
    input  logic [31:0] caseNext,
    output int valueErrors,
    output int otherErrors
);

    localparam logic [31:0] MEM_KEY = 32'hA5A50000;

    logic [31:0] modelPc;
    FetchId_t modelId;
    int sinceRedirect;
    logic prevRst = 1'b0;
    logic prevReady;
    BranchPred_t prevPred;
    Redirect_t prevRedirect;
    FetchId_t prevRob;
    PcFileEntry_t recEntry [16];
    logic [15:0] recValid = '0;
    logic [1:0] beatIdx = 2'd0;
    logic [27:0] fillLine;
    bit filledLines [logic [27:0]];

    initial begin
        valueErrors = 0;
        otherErrors = 0;
    end

    task checkValue(input string name, input logic [31:0] expVal, input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("ERROR %s expected %h got %h", name, expVal, gotVal);
            valueErrors++;
        end
    endtask

    task checkEntry(input string name, input PcFileEntry_t expEntry,
        input PcFileEntry_t gotEntry);
        checkValue({name, ".pc"}, 32'(expEntry.pc), 32'(gotEntry.pc));
        checkValue({name, ".predTaken"}, 32'(expEntry.predTaken), 32'(gotEntry.predTaken));
        checkValue({name, ".branchSlot"}, 32'(expEntry.branchSlot), 32'(gotEntry.branchSlot));
    endtask

    // everything is sampled on the falling edge, half a cycle away from the drive edge
    always @(negedge clk) begin
        logic [31:0] base;
        logic [31:0] nextPc;
        logic taken;
        logic ev;
        if (rst || prevRst) begin
            checkValue("blockValid", 32'd0, 32'(blockValid));
            checkValue("psel", 32'd0, 32'(apbReq.psel));
            checkValue("penable", 32'd0, 32'(apbReq.penable));
            modelPc = '0;
            modelId = '0;
            recValid = '0;
            beatIdx = 2'd0;
            filledLines.delete();
        end else if (blockValid) begin
            if (!prevReady || prevRedirect.valid || prevRob == modelId) begin
                $display("a block was delivered while fetch should have been held");
                otherErrors++;
            end
            base = {modelPc[31:4], 4'b0000};
            taken = (prevPred.kind == PRED_TAKEN) || (prevPred.kind == PRED_JUMP);
            for (int i = 0; i < SLOTS; i++) begin
                ev = (i >= int'(modelPc[3:2])) && (!taken || i <= int'(prevPred.srcSlot));
                checkValue($sformatf("slots[%0d].valid", i), 32'(ev), 32'(slots[i].valid));
                checkValue($sformatf("slots[%0d].pc", i), base + 32'(i * 4), slots[i].pc);
                checkValue($sformatf("slots[%0d].instr", i), (base + 32'(i * 4)) ^ MEM_KEY,
                    slots[i].instr);
                checkValue($sformatf("slots[%0d].fetchId", i), 32'(modelId),
                    32'(slots[i].fetchId));
                checkValue($sformatf("slots[%0d].predTaken", i),
                    32'(taken && i == int'(prevPred.srcSlot)), 32'(slots[i].predTaken));
            end
            recEntry[modelId] = '{pc: modelPc[31:2], predTaken: taken,
                branchSlot: prevPred.srcSlot};
            recValid[modelId] = 1'b1;
            if (sinceRedirect == 1) begin
                checkValue("slots[0].pc", {caseNext[31:4], 4'b0000}, slots[0].pc); // block after the first
            end
            nextPc = taken ? {prevPred.target[31:2], 2'b00} : base + 32'd16;
            sinceRedirect++;
            modelPc = nextPc;
            modelId = modelId + 4'd1;
        end else if (prevRedirect.valid) begin
            modelPc = {prevRedirect.pc[31:2], 2'b00};
            modelId = prevRedirect.fetchId + 4'd1;
            sinceRedirect = 0;
        end
        if (!rst && robFetchId == modelId && stall !== 1'b1) begin
            $display("stall stayed low while the rob held the current fetch id");
            otherErrors++;
        end
        if (!rst && !filledLines.exists(modelPc[31:4]) && stall !== 1'b1) begin
            $display("stall stayed low while the fetch line had never been filled");
            otherErrors++;
        end
        if (!rst && recValid[pcReadAddr0]) begin
            checkEntry("pcReadData0", recEntry[pcReadAddr0], pcReadData0);
        end
        if (!rst && recValid[pcReadAddr1]) begin
            checkEntry("pcReadData1", recEntry[pcReadAddr1], pcReadData1);
        end
        // each fill reads the four words of one line in order
        if (!rst && apbReq.psel && apbReq.penable && apbRsp.pready) begin
            if (beatIdx == 2'd0) begin
                fillLine = apbReq.paddr[31:4];
            end
            checkValue("paddr", {fillLine, beatIdx, 2'b00}, apbReq.paddr);
            checkValue("pwrite", 32'd0, 32'(apbReq.pwrite));
            if (beatIdx == 2'd3) begin
                filledLines[fillLine] = 1'b1; // the line can hit once its last word is in
            end
            beatIdx = beatIdx + 2'd1;
        end
        prevRst = rst;
        prevReady = ready;
        prevPred = pred;
        prevRedirect = redirect;
        prevRob = robFetchId;
    end

endmodule

// File: test/fetchTb.sv
`timescale 1ns/10ps

module fetchTb import fetchPkg::*;;

    logic clk = 1'b0;
    logic rst = 1'b1;
    BranchPred_t pred;
    Redirect_t redirect;
    logic ready;
    FetchId_t robFetchId;
    FetchId_t pcReadAddr0 = 4'd0;
    FetchId_t pcReadAddr1 = 4'd0;
    PcFileEntry_t pcReadData0;
    PcFileEntry_t pcReadData1;
    FetchSlot_t slots [SLOTS];
    logic blockValid;
    logic stall;
    ApbReq_t apbReq;
    ApbRsp_t apbRsp = '0;
    logic [31:0] caseNext = '0;
    int valueErrors;
    int otherErrors;
    logic [31:0] caseCol [32][7];
    int caseCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int waitLeft = 0;

    fetchTop fetchTop_inst (.clk(clk), .rst(rst), .pred(pred), .redirect(redirect),
        .ready(ready), .robFetchId(robFetchId), .pcReadAddr0(pcReadAddr0),
        .pcReadAddr1(pcReadAddr1), .pcReadData0(pcReadData0), .pcReadData1(pcReadData1),
        .slots(slots), .blockValid(blockValid), .stall(stall), .apbReq(apbReq),
        .apbRsp(apbRsp));

    fetchChecker checker_inst (.clk(clk), .rst(rst), .pred(pred), .redirect(redirect),
        .ready(ready), .robFetchId(robFetchId), .pcReadAddr0(pcReadAddr0),
        .pcReadAddr1(pcReadAddr1), .pcReadData0(pcReadData0), .pcReadData1(pcReadData1),
        .slots(slots), .blockValid(blockValid), .stall(stall), .apbReq(apbReq),
        .apbRsp(apbRsp), .caseNext(caseNext), .valueErrors(valueErrors),
        .otherErrors(otherErrors));

    initial begin
        forever #20 clk = ~clk;
    end

    // APB memory: data is the address xor a key, 0 to 3 wait states per read
    always @(posedge clk) begin
        int r;
        pcReadAddr0 <= pcReadAddr0 + 4'd1; // sweep both pc file ports
        pcReadAddr1 <= pcReadAddr1 - 4'd3;
        apbRsp.prdata <= apbReq.paddr ^ 32'hA5A50000;
        if (apbReq.psel && !apbReq.penable) begin
            r = int'($urandom % 4);
            apbRsp.pready <= (r == 0);
            waitLeft <= r - 1;
        end else if (apbReq.psel && !apbRsp.pready) begin
            if (waitLeft <= 0) apbRsp.pready <= 1'b1;
            else waitLeft <= waitLeft - 1;
        end else begin
            apbRsp.pready <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("no fetch block arrived before the cycle limit of %0d", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task loadCases;
        int fd;
        string line;
        logic [31:0] v [7];
        fd = $fopen("test/fetchCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != 8'h23 &&
                $sscanf(line, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5],
                    v[6]) == 7) begin
                caseCol[caseCount] = v;
                caseCount++;
            end
        end
        $fclose(fd);
    endtask

    task runCase(input int n);
        int blocks;
        blocks = 0;
        @(posedge clk);
        redirect <= '{valid: 1'b1, pc: caseCol[n][0], fetchId: caseCol[n][1][3:0]};
        pred <= '{kind: predKind_t'(caseCol[n][2][1:0]), srcSlot: caseCol[n][3][1:0],
            target: caseCol[n][4]};
        caseNext <= caseCol[n][6];
        ready <= (caseCol[n][5] == 0);
        robFetchId <= caseCol[n][1][3:0] + 4'd1; // the rob holds the restart id for a while
        @(posedge clk);
        redirect.valid <= 1'b0;
        repeat (3) @(posedge clk);
        robFetchId <= caseCol[n][1][3:0];
        repeat (int'(caseCol[n][5])) @(posedge clk);
        ready <= 1'b1;
        while (blocks < 2) begin
            @(negedge clk);
            if (blockValid) blocks++;
        end
        @(posedge clk);
        ready <= 1'b0;
    endtask

    initial begin
        pred = '0;
        redirect = '0;
        ready = 1'b0;
        robFetchId = '0;
        void'($urandom(66));
        loadCases();
        cycleLimit = (caseCount == 0) ? 200 : caseCount * 200;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        for (int n = 0; n < caseCount; n++) begin
            runCase(n);
        end
        repeat (4) @(posedge clk);
        $display("error count: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (caseCount > 0 && valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: fetchTop.f
verilog/fetchPkg.sv
verilog/fetchPc.sv
verilog/pcFile.sv
verilog/icacheArray.sv
verilog/fillControl.sv
verilog/fillCounter.sv
verilog/fetchTop.sv
test/fetchChecker.sv
test/fetchTb.sv

// File: run.sh
#!/bin/sh
# build and run from the project root
verilator --binary --timing -f fetchTop.f --top-module fetchTb -o fetchSim > build.log 2>&1 &&
./obj_dir/fetchSim > sim.log 2>&1 || { echo "build or simulation run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log && echo "test passed" || { echo "test failed"; exit 1; }

// File: test/fetchCases.txt
# redirectPc redirectId predKind srcSlot target readyLowCycles expectedNextPc (all hex)
# predKind 0 none, 1 not taken, 2 taken, 3 jump
00000100 3 0 0 00000000 0 00000110
00000108 5 1 2 00000000 2 00000110
00000114 7 2 2 00000240 0 00000240
0000024c 9 3 3 00000104 3 00000104
00000300 0 2 0 00000380 1 00000380
00000384 f 0 3 00000000 0 00000390
00000100 4 3 2 00000308 2 00000308
0000047c a 1 0 00000000 4 00000480
00000480 c 2 3 00000124 0 00000124
00000204 1 0 0 00000000 1 00000210
00000538 6 2 1 0000061c 2 0000061c
00000620 e 1 3 00000000 0 00000630
